// ==== hdl/i2c_pkg.sv ====
package i2c_pkg;

	// protocol phases of one transaction
	typedef enum logic [2:0] {
		IDLE,
		START,
		ADDR,
		ACK_ADDR,
		WDATA,
		RDATA,
		ACK_DATA,
		STOP
	} i2c_state_e;

	// register byte offsets on the host bus
	localparam logic [4:0] REG_NBY = 5'd0;
	localparam logic [4:0] REG_ADR = 5'd4;
	localparam logic [4:0] REG_RDR = 5'd8;
	localparam logic [4:0] REG_TDR = 5'd12;
	localparam logic [4:0] REG_CFG = 5'd16;

	// one SCL period is twice this many system clocks
	localparam logic [7:0] SCL_HALF = 8'd75;

	// bit positions in the configuration register
	localparam int CFG_START = 0;
	localparam int CFG_READ  = 1;
	localparam int CFG_DONE  = 2;
	localparam int CFG_NACK  = 3;

endpackage

// ==== hdl/i2c_regs.sv ====
`timescale 1ns/1ps

module i2c_regs (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        write_i,
	input  logic [3:0]  data_be_i,
	input  logic [4:0]  addr_i,
	input  logic [31:0] wdata_i,
	output logic [31:0] rdata_o,
	output logic        cfg_start_o,
	output logic        cfg_read_o,
	output logic [2:0]  nby_o,
	output logic [6:0]  saddr_o,
	output logic [31:0] tdr_o,
	input  logic        rx_clear_i,
	input  logic        rx_bit_we_i,
	input  logic [4:0]  rx_bit_idx_i,
	input  logic        rx_bit_i,
	input  logic        xfer_done_i,
	input  logic        xfer_nack_i
);
	import i2c_pkg::*;

	logic [31:0] nby_q;
	logic [31:0] adr_q;
	logic [31:0] rdr_q;
	logic [31:0] tdr_q;
	logic [31:0] cfg_q;

	function automatic logic [31:0] be_merge(input logic [31:0] old_v,
		input logic [31:0] new_v, input logic [3:0] be);
		logic [31:0] res;
		res = old_v;
		for (int i = 0; i < 4; i++) begin
			if (be[i])
				res[8*i +: 8] = new_v[8*i +: 8];
		end
		return res;
	endfunction

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			nby_q <= '0;
			adr_q <= '0;
			rdr_q <= '0;
			tdr_q <= '0;
			cfg_q <= '0;
		end else begin
			if (write_i) begin
				case (addr_i)
					REG_NBY: nby_q <= be_merge(nby_q, wdata_i, data_be_i);
					REG_ADR: adr_q <= be_merge(adr_q, wdata_i, data_be_i);
					REG_RDR: rdr_q <= be_merge(rdr_q, wdata_i, data_be_i);
					REG_TDR: tdr_q <= be_merge(tdr_q, wdata_i, data_be_i);
					REG_CFG: begin
						cfg_q <= be_merge(cfg_q, wdata_i, data_be_i);
						// a new start wipes the status of the previous transfer
						if (data_be_i[0] && wdata_i[CFG_START]) begin
							cfg_q[CFG_DONE] <= 1'b0;
							cfg_q[CFG_NACK] <= 1'b0;
						end
					end
					default: ;
				endcase
			end
			// engine updates come last so they override a host write in the same cycle
			if (rx_clear_i)
				rdr_q <= '0;
			if (rx_bit_we_i)
				rdr_q[rx_bit_idx_i] <= rx_bit_i;
			if (xfer_done_i) begin
				cfg_q[CFG_START] <= 1'b0;
				cfg_q[CFG_DONE]  <= 1'b1;
				cfg_q[CFG_NACK]  <= xfer_nack_i;
			end
		end
	end

	always_comb begin
		case (addr_i)
			REG_NBY: rdata_o = nby_q;
			REG_ADR: rdata_o = adr_q;
			REG_RDR: rdata_o = rdr_q;
			REG_TDR: rdata_o = tdr_q;
			REG_CFG: rdata_o = cfg_q;
			default: rdata_o = '0;
		endcase
	end

	// zero bytes still moves one byte, anything above four is capped
	always_comb begin
		if (nby_q > 32'd4)
			nby_o = 3'd4;
		else if (nby_q == 32'd0)
			nby_o = 3'd1;
		else
			nby_o = nby_q[2:0];
	end

	assign cfg_start_o = cfg_q[CFG_START];
	assign cfg_read_o  = cfg_q[CFG_READ];
	assign saddr_o     = adr_q[6:0];
	assign tdr_o       = tdr_q;

endmodule

// ==== hdl/i2c_scl_gen.sv ====
`timescale 1ns/1ps

module i2c_scl_gen (
	input  logic clk_i,
	input  logic rst_i,
	input  logic run_i,
	output logic scl_o,
	output logic rise_o,
	output logic fall_o
);
	import i2c_pkg::*;

	logic [7:0] cnt_q;
	logic       scl_q;
	logic       rise_q;
	logic       fall_q;
	logic       toggle;

	assign toggle = (cnt_q == SCL_HALF - 8'd1);

	// strobes are high in the first cycle that shows the new SCL level
	always_ff @(posedge clk_i) begin
		if (rst_i || !run_i) begin
			cnt_q  <= '0;
			scl_q  <= 1'b1;
			rise_q <= 1'b0;
			fall_q <= 1'b0;
		end else begin
			rise_q <= toggle && !scl_q;
			fall_q <= toggle && scl_q;
			if (toggle) begin
				cnt_q <= '0;
				scl_q <= ~scl_q;
			end else begin
				cnt_q <= cnt_q + 8'd1;
			end
		end
	end

	assign scl_o  = scl_q;
	assign rise_o = rise_q;
	assign fall_o = fall_q;

endmodule

// ==== hdl/i2c_byte_fsm.sv ====
`timescale 1ns/1ps

module i2c_byte_fsm (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        cfg_start_i,
	input  logic        cfg_read_i,
	input  logic [2:0]  nby_i,
	input  logic [6:0]  saddr_i,
	input  logic [31:0] tdr_i,
	input  logic        scl_rise_i,
	input  logic        scl_fall_i,
	input  logic        sda_i,
	output logic        scl_run_o,
	output logic        sda_o,
	output logic        sda_oe_o,
	output logic        rx_clear_o,
	output logic        rx_bit_we_o,
	output logic [4:0]  rx_bit_idx_o,
	output logic        rx_bit_o,
	output logic        xfer_done_o,
	output logic        xfer_nack_o
);
	import i2c_pkg::*;

	i2c_state_e state_q, state_d;
	logic [2:0] bit_cnt_q, bit_cnt_d;
	logic [1:0] byte_cnt_q, byte_cnt_d;
	logic       read_q, read_d;
	logic       nack_q, nack_d;
	logic       sda_oe_q, sda_oe_d;
	logic [7:0] addr_byte;
	logic [2:0] nby_last;

	assign addr_byte = {saddr_i, read_q};
	assign nby_last  = nby_i - 3'd1;

	always_comb begin
		state_d    = state_q;
		bit_cnt_d  = bit_cnt_q;
		byte_cnt_d = byte_cnt_q;
		read_d     = read_q;
		nack_d     = nack_q;
		sda_oe_d   = sda_oe_q;
		case (state_q)
			IDLE: begin
				sda_oe_d = 1'b0;
				// pulling SDA low while SCL is parked high is the START condition
				if (cfg_start_i) begin
					state_d    = START;
					read_d     = cfg_read_i;
					nack_d     = 1'b0;
					byte_cnt_d = nby_last[1:0];
					sda_oe_d   = 1'b1;
				end
			end
			START: begin
				if (scl_fall_i) begin
					state_d   = ADDR;
					bit_cnt_d = 3'd7;
					sda_oe_d  = !addr_byte[7];
				end
			end
			ADDR: begin
				if (scl_fall_i) begin
					if (bit_cnt_q == 3'd0) begin
						state_d  = ACK_ADDR;
						sda_oe_d = 1'b0;
					end else begin
						bit_cnt_d = bit_cnt_q - 3'd1;
						sda_oe_d  = !addr_byte[bit_cnt_d];
					end
				end
			end
			ACK_ADDR: begin
				if (scl_rise_i)
					nack_d = sda_i;
				if (scl_fall_i) begin
					bit_cnt_d = 3'd7;
					if (nack_q) begin
						state_d  = STOP;
						sda_oe_d = 1'b1;
					end else if (read_q) begin
						state_d  = RDATA;
						sda_oe_d = 1'b0;
					end else begin
						state_d  = WDATA;
						sda_oe_d = !tdr_i[{byte_cnt_q, 3'd7}];
					end
				end
			end
			WDATA: begin
				if (scl_fall_i) begin
					if (bit_cnt_q == 3'd0) begin
						state_d  = ACK_DATA;
						sda_oe_d = 1'b0;
					end else begin
						bit_cnt_d = bit_cnt_q - 3'd1;
						sda_oe_d  = !tdr_i[{byte_cnt_q, bit_cnt_d}];
					end
				end
			end
			RDATA: begin
				if (scl_fall_i) begin
					if (bit_cnt_q == 3'd0) begin
						// ack every byte but the last one
						state_d  = ACK_DATA;
						sda_oe_d = (byte_cnt_q != 2'd0);
					end else begin
						bit_cnt_d = bit_cnt_q - 3'd1;
					end
				end
			end
			ACK_DATA: begin
				if (scl_rise_i && !read_q)
					nack_d = sda_i;
				if (scl_fall_i) begin
					bit_cnt_d = 3'd7;
					if (nack_q || byte_cnt_q == 2'd0) begin
						state_d  = STOP;
						sda_oe_d = 1'b1;
					end else begin
						byte_cnt_d = byte_cnt_q - 2'd1;
						if (read_q) begin
							state_d  = RDATA;
							sda_oe_d = 1'b0;
						end else begin
							state_d  = WDATA;
							sda_oe_d = !tdr_i[{byte_cnt_d, 3'd7}];
						end
					end
				end
			end
			STOP: begin
				// releasing SDA while SCL is high is the STOP condition
				if (scl_rise_i) begin
					state_d  = IDLE;
					sda_oe_d = 1'b0;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q    <= IDLE;
			bit_cnt_q  <= '0;
			byte_cnt_q <= '0;
			read_q     <= 1'b0;
			nack_q     <= 1'b0;
			sda_oe_q   <= 1'b0;
		end else begin
			state_q    <= state_d;
			bit_cnt_q  <= bit_cnt_d;
			byte_cnt_q <= byte_cnt_d;
			read_q     <= read_d;
			nack_q     <= nack_d;
			sda_oe_q   <= sda_oe_d;
		end
	end

	assign scl_run_o = (state_q != IDLE);

	// the pad is open drain and only ever pulls the wire low
	assign sda_o    = 1'b0;
	assign sda_oe_o = sda_oe_q;

	assign rx_clear_o   = (state_q == IDLE) && cfg_start_i && cfg_read_i;
	assign rx_bit_we_o  = (state_q == RDATA) && scl_rise_i;
	assign rx_bit_idx_o = {byte_cnt_q, bit_cnt_q};
	assign rx_bit_o     = sda_i;
	assign xfer_done_o  = (state_q == STOP) && scl_rise_i;
	assign xfer_nack_o  = nack_q;

endmodule

// ==== hdl/i2c_master.sv ====
`timescale 1ns/1ps

module i2c_master (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        write_i,
	input  logic [3:0]  data_be_i,
	input  logic [4:0]  addr_i,
	input  logic [31:0] wdata_i,
	output logic [31:0] rdata_o,
	input  logic        sda_i,
	output logic        sda_o,
	output logic        sda_oe_o,
	output logic        scl_o
);

	logic        cfg_start;
	logic        cfg_read;
	logic [2:0]  nby;
	logic [6:0]  saddr;
	logic [31:0] tdr;
	logic        rx_clear;
	logic        rx_bit_we;
	logic [4:0]  rx_bit_idx;
	logic        rx_bit;
	logic        xfer_done;
	logic        xfer_nack;
	logic        scl_run;
	logic        scl_rise;
	logic        scl_fall;

	i2c_regs regs_i (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.write_i      (write_i),
		.data_be_i    (data_be_i),
		.addr_i       (addr_i),
		.wdata_i      (wdata_i),
		.rdata_o      (rdata_o),
		.cfg_start_o  (cfg_start),
		.cfg_read_o   (cfg_read),
		.nby_o        (nby),
		.saddr_o      (saddr),
		.tdr_o        (tdr),
		.rx_clear_i   (rx_clear),
		.rx_bit_we_i  (rx_bit_we),
		.rx_bit_idx_i (rx_bit_idx),
		.rx_bit_i     (rx_bit),
		.xfer_done_i  (xfer_done),
		.xfer_nack_i  (xfer_nack)
	);

	i2c_scl_gen scl_gen_i (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.run_i  (scl_run),
		.scl_o  (scl_o),
		.rise_o (scl_rise),
		.fall_o (scl_fall)
	);

	i2c_byte_fsm byte_fsm_i (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.cfg_start_i  (cfg_start),
		.cfg_read_i   (cfg_read),
		.nby_i        (nby),
		.saddr_i      (saddr),
		.tdr_i        (tdr),
		.scl_rise_i   (scl_rise),
		.scl_fall_i   (scl_fall),
		.sda_i        (sda_i),
		.scl_run_o    (scl_run),
		.sda_o        (sda_o),
		.sda_oe_o     (sda_oe_o),
		.rx_clear_o   (rx_clear),
		.rx_bit_we_o  (rx_bit_we),
		.rx_bit_idx_o (rx_bit_idx),
		.rx_bit_o     (rx_bit),
		.xfer_done_o  (xfer_done),
		.xfer_nack_o  (xfer_nack)
	);

endmodule

// ==== test/i2c_slave_model.sv ====
`timescale 1ns/1ps

module i2c_slave_model (
	input  logic clk_i,
	input  logic rst_i,
	input  logic scl_i,
	input  logic sda_i,
	output logic sda_oe_o
);

	localparam logic [6:0] OWN_ADDR = 7'h2a;

	typedef enum logic [2:0] {
		S_IDLE,
		S_ADDR,
		S_ADDR_ACK,
		S_WR,
		S_WR_ACK,
		S_RD,
		S_RD_ACK
	} slave_state_e;

	logic [7:0]   read_pattern [4] = '{8'ha5, 8'h3c, 8'h96, 8'h0f};
	slave_state_e state;
	logic         scl_q;
	logic         sda_q;
	logic [7:0]   shift;
	logic [3:0]   bit_cnt;
	logic [1:0]   rd_idx;
	logic         rw;
	logic         master_nack;
	logic         start_seen;
	logic         stop_seen;
	logic         scl_rise;
	logic         scl_fall;

	// bytes written by the master and the master's ack bits on reads where 1 means NACK
	logic [7:0]   rx_bytes [$];
	logic         ack_log [$];

	// the bus is oversampled with the system clock
	assign start_seen = scl_i && scl_q && sda_q && !sda_i;
	assign stop_seen  = scl_i && scl_q && !sda_q && sda_i;
	assign scl_rise   = scl_i && !scl_q;
	assign scl_fall   = !scl_i && scl_q;

	always @(posedge clk_i) begin
		scl_q <= scl_i;
		sda_q <= sda_i;
		if (rst_i) begin
			state       <= S_IDLE;
			sda_oe_o    <= 1'b0;
			shift       <= '0;
			bit_cnt     <= '0;
			rd_idx      <= '0;
			rw          <= 1'b0;
			master_nack <= 1'b0;
		end else if (start_seen) begin
			state    <= S_ADDR;
			bit_cnt  <= '0;
			rd_idx   <= '0;
			sda_oe_o <= 1'b0;
			rx_bytes.delete();
			ack_log.delete();
		end else if (stop_seen) begin
			state    <= S_IDLE;
			sda_oe_o <= 1'b0;
		end else if (scl_rise) begin
			if (state == S_ADDR || state == S_WR) begin
				shift   <= {shift[6:0], sda_i};
				bit_cnt <= bit_cnt + 4'd1;
			end else if (state == S_RD_ACK) begin
				ack_log.push_back(sda_i);
				master_nack <= sda_i;
			end
		end else if (scl_fall) begin
			case (state)
				S_ADDR: begin
					if (bit_cnt == 4'd8) begin
						// a foreign address leaves the bus alone until the next START
						if (shift[7:1] == OWN_ADDR) begin
							state    <= S_ADDR_ACK;
							sda_oe_o <= 1'b1;
							rw       <= shift[0];
						end else begin
							state <= S_IDLE;
						end
					end
				end
				S_ADDR_ACK: begin
					if (rw) begin
						state    <= S_RD;
						sda_oe_o <= !read_pattern[rd_idx][7];
						bit_cnt  <= 4'd1;
					end else begin
						state    <= S_WR;
						sda_oe_o <= 1'b0;
						bit_cnt  <= 4'd0;
					end
				end
				S_WR: begin
					if (bit_cnt == 4'd8) begin
						rx_bytes.push_back(shift);
						state    <= S_WR_ACK;
						sda_oe_o <= 1'b1;
					end
				end
				S_WR_ACK: begin
					state    <= S_WR;
					bit_cnt  <= 4'd0;
					sda_oe_o <= 1'b0;
				end
				S_RD: begin
					if (bit_cnt == 4'd8) begin
						state    <= S_RD_ACK;
						sda_oe_o <= 1'b0;
					end else begin
						sda_oe_o <= !read_pattern[rd_idx][3'd7 - bit_cnt[2:0]];
						bit_cnt  <= bit_cnt + 4'd1;
					end
				end
				S_RD_ACK: begin
					if (master_nack) begin
						state    <= S_IDLE;
						sda_oe_o <= 1'b0;
					end else begin
						state    <= S_RD;
						rd_idx   <= rd_idx + 2'd1;
						sda_oe_o <= !read_pattern[rd_idx + 2'd1][7];
						bit_cnt  <= 4'd1;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== test/i2c_master_asserts.sv ====
`timescale 1ns/1ps

module i2c_master_asserts (
	input logic                clk_i,
	input logic                rst_i,
	input logic                scl_i,
	input logic                sda_oe_i,
	input i2c_pkg::i2c_state_e state_i
);
	import i2c_pkg::*;

	int unsigned sda_err = 0;
	int unsigned scl_err = 0;
	int unsigned rst_err = 0;
	int unsigned fail_cnt;

	assign fail_cnt = sda_err + scl_err + rst_err;

	// with SCL high, SDA may only move to form a START or a STOP
	sda_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
		(scl_i && $past(scl_i) && (sda_oe_i != $past(sda_oe_i)))
		|-> ($past(state_i) == IDLE || $past(state_i) == STOP))
	else begin
		$error("SDA changed while SCL was high outside a START or STOP");
		sda_err++;
	end

	sda_idle_scl_a: assert property (@(posedge clk_i) disable iff (rst_i)
		(state_i == IDLE) |-> scl_i)
	else begin
		$error("SCL was low while the engine was idle");
		scl_err++;
	end

	oe_after_reset_a: assert property (@(posedge clk_i) rst_i |=> !sda_oe_i)
	else begin
		$error("SDA output enable was active after reset");
		rst_err++;
	end

endmodule

// ==== include/i2c_regmap.svh ====
`ifndef I2C_REGMAP_SVH
`define I2C_REGMAP_SVH
`define I2C_REG_NBY 5'd0
`define I2C_REG_ADR 5'd4
`define I2C_REG_RDR 5'd8
`define I2C_REG_TDR 5'd12
`define I2C_REG_CFG 5'd16
`endif

// ==== test/tb_i2c_master.sv ====
`timescale 1ns/1ps
`include "i2c_regmap.svh"

module tb_i2c_master;

	localparam logic [6:0] SLAVE_ADDR = 7'h2a;
	localparam logic [6:0] WRONG_ADDR = 7'h15;
	localparam int SCL_PERIOD = 150;
	// a four byte transfer takes about 9 * 4 + 11 SCL periods
	localparam int WATCHDOG_CYCLES = 20 * SCL_PERIOD * 47;

	logic        clk_i;
	logic        rst_i;
	logic        write;
	logic [3:0]  data_be;
	logic [4:0]  addr;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic        sda_out;
	logic        sda_oe;
	logic        scl;
	logic        slave_oe;
	wire         sda_bus;
	int unsigned errors;
	logic [7:0]  read_pattern [4] = '{8'ha5, 8'h3c, 8'h96, 8'h0f};

	// wired AND with a pull-up
	assign sda_bus = (sda_oe ? sda_out : 1'b1) & !slave_oe;

	i2c_master i2c_master_i (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.write_i   (write),
		.data_be_i (data_be),
		.addr_i    (addr),
		.wdata_i   (wdata),
		.rdata_o   (rdata),
		.sda_i     (sda_bus),
		.sda_o     (sda_out),
		.sda_oe_o  (sda_oe),
		.scl_o     (scl)
	);

	i2c_slave_model slave_i (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.scl_i    (scl),
		.sda_i    (sda_bus),
		.sda_oe_o (slave_oe)
	);

	bind i2c_master i2c_master_asserts asserts_i (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.scl_i    (scl_o),
		.sda_oe_i (sda_oe_o),
		.state_i  (byte_fsm_i.state_q)
	);

	initial clk_i = 1'b0;
	always #5 clk_i = ~clk_i;

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			errors++;
			$display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic host_write(input logic [4:0] a, input logic [31:0] d, input logic [3:0] be);
		@(posedge clk_i);
		write   <= 1'b1;
		addr    <= a;
		wdata   <= d;
		data_be <= be;
		@(posedge clk_i);
		write   <= 1'b0;
		data_be <= 4'h0;
	endtask

	task automatic host_read(input logic [4:0] a, output logic [31:0] d);
		@(posedge clk_i);
		addr <= a;
		@(negedge clk_i);
		d = rdata;
	endtask

	task automatic wait_done();
		logic [31:0] cfg;
		int          polls;
		cfg   = '0;
		polls = 0;
		while (!cfg[2] && polls < 20000) begin
			host_read(`I2C_REG_CFG, cfg);
			polls++;
		end
		assert (cfg[2]) else begin
			errors++;
			$display("transfer at %0t ns never set the done bit", $time);
		end
	endtask

	task automatic check_status(input logic exp_nack);
		logic [31:0] cfg;
		host_read(`I2C_REG_CFG, cfg);
		check_value("cfg start", 32'd0, {31'd0, cfg[0]});
		check_value("cfg done", 32'd1, {31'd0, cfg[2]});
		check_value("cfg nack", {31'd0, exp_nack}, {31'd0, cfg[3]});
	endtask

	task automatic start_transfer(input logic [31:0] nby_reg, input logic [6:0] saddr,
		input logic rd);
		host_write(`I2C_REG_NBY, nby_reg, 4'hf);
		host_write(`I2C_REG_ADR, {25'd0, saddr}, 4'hf);
		host_write(`I2C_REG_CFG, {30'd0, rd, 1'b1}, 4'h1);
		wait_done();
	endtask

	// TDR is already loaded and n is the number of bytes the slave must see
	task automatic send_and_check(input logic [31:0] nby_reg, input logic [31:0] tdr_val,
		input int n);
		logic [7:0] exp_byte;
		int         i;
		start_transfer(nby_reg, SLAVE_ADDR, 1'b0);
		check_status(1'b0);
		check_value("slave byte count", 32'(n), 32'(slave_i.rx_bytes.size()));
		for (i = 0; i < n && i < slave_i.rx_bytes.size(); i++) begin
			exp_byte = tdr_val[8 * (n - 1 - i) +: 8];
			check_value("slave rx byte", {24'd0, exp_byte}, {24'd0, slave_i.rx_bytes[i]});
		end
	endtask

	task automatic read_transfer(input int n);
		logic [31:0] rdr;
		logic [31:0] exp_rdr;
		int          i;
		exp_rdr = '0;
		for (i = 0; i < n; i++)
			exp_rdr[8 * (n - 1 - i) +: 8] = read_pattern[i];
		start_transfer(32'(n), SLAVE_ADDR, 1'b1);
		check_status(1'b0);
		host_read(`I2C_REG_RDR, rdr);
		check_value("rdr", exp_rdr, rdr);
		check_value("master ack count", 32'(n), 32'(slave_i.ack_log.size()));
		for (i = 0; i < n && i < slave_i.ack_log.size(); i++)
			check_value("master ack bit", (i == n - 1) ? 32'd1 : 32'd0,
				{31'd0, slave_i.ack_log[i]});
	endtask

	initial begin
		logic [31:0] value;
		logic [31:0] tdr_val;
		int          n;
		errors  = 0;
		void'($urandom(94));
		rst_i   <= 1'b1;
		write   <= 1'b0;
		data_be <= 4'h0;
		addr    <= 5'd0;
		wdata   <= 32'd0;
		repeat (4) @(posedge clk_i);
		rst_i <= 1'b0;

		@(negedge clk_i);
		check_value("scl_o", 32'd1, {31'd0, scl});
		check_value("sda bus", 32'd1, {31'd0, sda_bus});
		for (n = 0; n < 5; n++) begin
			host_read(5'(4 * n), value);
			check_value($sformatf("register at offset %0d", 4 * n), 32'd0, value);
		end

		for (n = 1; n <= 4; n++) begin
			tdr_val = $urandom;
			host_write(`I2C_REG_TDR, tdr_val, 4'hf);
			send_and_check(32'(n), tdr_val, n);
		end
		repeat (2) begin
			n       = int'($urandom % 4) + 1;
			tdr_val = $urandom;
			host_write(`I2C_REG_TDR, tdr_val, 4'hf);
			send_and_check(32'(n), tdr_val, n);
		end

		// counts go down so that a stale upper RDR byte would show up
		for (n = 4; n >= 1; n--)
			read_transfer(n);

		// nobody answers this address
		host_write(`I2C_REG_TDR, $urandom, 4'hf);
		start_transfer(32'd2, WRONG_ADDR, 1'b0);
		check_status(1'b1);
		check_value("slave byte count", 32'd0, 32'(slave_i.rx_bytes.size()));

		host_write(`I2C_REG_TDR, 32'h11223344, 4'hf);
		host_write(`I2C_REG_TDR, 32'haabbccdd, 4'b0101);
		host_read(`I2C_REG_TDR, value);
		check_value("tdr after partial write", 32'h11bb33dd, value);
		send_and_check(32'd4, 32'h11bb33dd, 4);

		tdr_val = $urandom;
		host_write(`I2C_REG_TDR, tdr_val, 4'hf);
		send_and_check(32'd0, tdr_val, 1);
		tdr_val = $urandom;
		host_write(`I2C_REG_TDR, tdr_val, 4'hf);
		send_and_check(32'd7, tdr_val, 4);

		repeat (10) @(posedge clk_i);
		$display("check errors: %0d, assertion failures: %0d", errors,
			i2c_master_i.asserts_i.fail_cnt);
		if (errors == 0 && i2c_master_i.asserts_i.fail_cnt == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * 10);
		$display("watchdog expired after %0d clock cycles, the tests did not finish",
			WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== i2c_master.f ====
+incdir+include
hdl/i2c_pkg.sv
hdl/i2c_regs.sv
hdl/i2c_scl_gen.sv
hdl/i2c_byte_fsm.sv
hdl/i2c_master.sv
test/i2c_slave_model.sv
test/i2c_master_asserts.sv
test/tb_i2c_master.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f i2c_master.f --top-module tb_i2c_master -o tb_sim &&
./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log 2>/dev/null && echo "run passed" ||
	{ echo "run failed"; exit 1; }
